/* hw/alu_params.svh */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand width of the datapath.
`define ALU_WIDTH       32

// only the low bits of opB steer shifts and rotates.
`define ALU_SHAMT_WIDTH 5

// an opcode is a unit field above a function field.
`define ALU_UNIT_WIDTH  2
`define ALU_FUNC_WIDTH  4

// the flag word holds carry, overflow, both parities, sign and zero.
`define ALU_FLAG_COUNT  6

`endif

/* hw/aluOpPkg.sv */
`include "alu_params.svh"

package aluOpPkg;

    // the logic unit owns two pages of opcodes because it has more than sixteen functions.
    typedef enum logic [`ALU_UNIT_WIDTH-1:0] {
        UNIT_NONE  = 2'b00,
        UNIT_ARITH = 2'b01,
        UNIT_LOGIC = 2'b10, // bitwise page.
        UNIT_BITS  = 2'b11  // shift, count and reorder page.
    } aluUnit_e;

    typedef enum logic [`ALU_UNIT_WIDTH+`ALU_FUNC_WIDTH-1:0] {
        ALU_NOP    = 6'h00,
        ALU_ADD    = 6'h10,
        ALU_SUB    = 6'h11,
        ALU_INCA   = 6'h12,
        ALU_DECA   = 6'h13,
        ALU_NEG    = 6'h14,
        ALU_ABS    = 6'h15,
        ALU_SLT    = 6'h16,
        ALU_SLTU   = 6'h17,
        ALU_MIN    = 6'h18,
        ALU_MINU   = 6'h19,
        ALU_MAX    = 6'h1a,
        ALU_MAXU   = 6'h1b, // 6'h1c was the multiply code.
        ALU_AND    = 6'h20,
        ALU_OR     = 6'h21,
        ALU_XOR    = 6'h22,
        ALU_NAND   = 6'h23,
        ALU_NOR    = 6'h24,
        ALU_XNOR   = 6'h25,
        ALU_ANDN   = 6'h26,
        ALU_ORN    = 6'h27,
        ALU_XORN   = 6'h28,
        ALU_NOT    = 6'h29,
        ALU_SLL    = 6'h30,
        ALU_SRL    = 6'h31,
        ALU_SRA    = 6'h32,
        ALU_ROL    = 6'h33,
        ALU_ROR    = 6'h34,
        ALU_CLZ    = 6'h35,
        ALU_CTZ    = 6'h36,
        ALU_PCNT   = 6'h37,
        ALU_BITREV = 6'h38,
        ALU_BSWAP  = 6'h39
    } aluOp_e;

    typedef struct packed {
        aluUnit_e                   unit;
        logic [`ALU_FUNC_WIDTH-1:0] func;
    } aluOpFields_s;

    typedef union packed {
        aluOp_e       op;
        aluOpFields_s fields;
    } aluOpWord_u;

    localparam int arithFuncCount = 12;
    localparam int logicFuncCount = 10;
    localparam int bitsFuncCount  = 10;

    // function codes past the end of a page route to no unit and so act as NOP.
    function automatic aluUnit_e unitOf(aluOpWord_u word);
        logic known;
        case (word.fields.unit)
            UNIT_ARITH: known = word.fields.func < arithFuncCount;
            UNIT_LOGIC: known = word.fields.func < logicFuncCount;
            UNIT_BITS:  known = word.fields.func < bitsFuncCount;
            default:    known = 1'b0;
        endcase
        return known ? word.fields.unit : UNIT_NONE;
    endfunction

endpackage

/* hw/aluResultPkg.sv */
`include "alu_params.svh"

package aluResultPkg;

    typedef struct packed {
        logic carryOut;   // borrow for subtraction and decrement.
        logic overflow;
        logic evenParity; // set when the result holds an even number of ones.
        logic oddParity;
        logic sign;
        logic zero;
    } aluFlags_s;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] opA;
        logic [`ALU_WIDTH-1:0] opB;
        logic                  cIn;
        aluOpPkg::aluOpWord_u  op;
    } aluRequest_s;

    // what each unit hands back before the flags are derived.
    typedef struct packed {
        logic [`ALU_WIDTH-1:0] value;
        logic                  carryOut;
        logic                  overflow;
    } unitResult_s;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] result;
        aluFlags_s             flags;
        logic                  outValid;
    } aluResponse_s;

endpackage

/* hw/ArithmeticOps.sv */
`include "alu_params.svh"

module ArithmeticOps (
    input  aluOpPkg::aluOp_e          op,
    input  logic [`ALU_WIDTH-1:0]     opA,
    input  logic [`ALU_WIDTH-1:0]     opB,
    input  logic                      cIn,
    output aluResultPkg::unitResult_s res
);
    import aluOpPkg::*;

    localparam int msb = `ALU_WIDTH - 1;

    logic [`ALU_WIDTH-1:0] addB;
    logic [`ALU_WIDTH-1:0] addBEff;
    logic [`ALU_WIDTH-1:0] addSum;
    logic [`ALU_WIDTH-1:0] negA;
    logic                  addCin;
    logic                  addSub;
    logic                  rawCarry;
    logic                  addCarry;
    logic                  addOverflow;
    logic                  lessSigned;
    logic                  lessUnsigned;

    // ADD, SUB, INCA and DECA share one adder.
    always_comb begin
        addB   = opB;
        addCin = cIn;
        addSub = 1'b0;
        case (op)
            ALU_SUB: begin
                addSub = 1'b1;
            end
            ALU_INCA: begin
                addB   = `ALU_WIDTH'(1);
                addCin = 1'b0;
            end
            ALU_DECA: begin
                addB   = `ALU_WIDTH'(1);
                addCin = 1'b0;
                addSub = 1'b1;
            end
            default: ;
        endcase
    end

    // subtraction adds the inverted operand and turns the carry-in into a borrow-in.
    assign addBEff = addSub ? ~addB : addB;
    assign {rawCarry, addSum} = {1'b0, opA} + {1'b0, addBEff}
                              + (`ALU_WIDTH+1)'(addSub ^ addCin);

    assign addCarry    = rawCarry ^ addSub; // a missing carry on subtraction is a borrow.
    assign addOverflow = (opA[msb] == addBEff[msb]) && (addSum[msb] != opA[msb]);

    assign negA = ~opA + `ALU_WIDTH'(1);

    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb begin
        res = '0;
        case (op)
            ALU_ADD, ALU_SUB, ALU_INCA, ALU_DECA: begin
                res.value    = addSum;
                res.carryOut = addCarry;
                res.overflow = addOverflow;
            end
            ALU_NEG: begin
                res.value = negA;
            end
            ALU_ABS: begin
                res.value = opA[msb] ? negA : opA;
                // only the most negative value is still negative after negation.
                res.overflow = opA[msb] & negA[msb];
            end
            ALU_SLT: begin
                res.value = `ALU_WIDTH'(lessSigned);
            end
            ALU_SLTU: begin
                res.value = `ALU_WIDTH'(lessUnsigned);
            end
            ALU_MIN: begin
                res.value = lessSigned ? opA : opB;
            end
            ALU_MINU: begin
                res.value = lessUnsigned ? opA : opB;
            end
            ALU_MAX: begin
                res.value = lessSigned ? opB : opA;
            end
            ALU_MAXU: begin
                res.value = lessUnsigned ? opB : opA;
            end
            default: ; // anything else belongs to another unit.
        endcase
    end

endmodule

/* hw/LogicOps.sv */
`include "alu_params.svh"

module LogicOps (
    input  aluOpPkg::aluOp_e          op,
    input  logic [`ALU_WIDTH-1:0]     opA,
    input  logic [`ALU_WIDTH-1:0]     opB,
    output aluResultPkg::unitResult_s res
);
    import aluOpPkg::*;

    // wide enough to hold a count of 32.
    localparam int countWidth = $clog2(`ALU_WIDTH + 1);

    logic [`ALU_SHAMT_WIDTH-1:0] shamt;
    logic [2*`ALU_WIDTH-1:0]     rotLeft;
    logic [2*`ALU_WIDTH-1:0]     rotRight;
    logic [`ALU_WIDTH-1:0]       bitRev;
    logic [`ALU_WIDTH-1:0]       byteSwap;
    logic [countWidth-1:0]       leadZeros;
    logic [countWidth-1:0]       trailZeros;
    logic [countWidth-1:0]       onesCount;

    assign shamt = opB[`ALU_SHAMT_WIDTH-1:0];

    // shifting a doubled word leaves the rotated word in one half.
    assign rotLeft  = {opA, opA} << shamt;
    assign rotRight = {opA, opA} >> shamt;

    assign bitRev   = {<<{opA}};
    assign byteSwap = {<<8{opA}};

    always_comb begin
        leadZeros  = countWidth'(`ALU_WIDTH); // a zero word counts as all zeros.
        trailZeros = countWidth'(`ALU_WIDTH);
        onesCount  = '0;
        for (int i = 0; i < `ALU_WIDTH; i++) begin
            // the highest set bit is the last one seen going up.
            if (opA[i]) begin
                leadZeros = countWidth'(`ALU_WIDTH - 1 - i);
            end
            // the lowest set bit is the last one seen going down.
            if (opA[`ALU_WIDTH - 1 - i]) begin
                trailZeros = countWidth'(`ALU_WIDTH - 1 - i);
            end
            onesCount = onesCount + countWidth'(opA[i]);
        end
    end

    always_comb begin
        res = '0; // this unit never reports carry or overflow.
        case (op)
            ALU_AND: begin
                res.value = opA & opB;
            end
            ALU_OR: begin
                res.value = opA | opB;
            end
            ALU_XOR: begin
                res.value = opA ^ opB;
            end
            ALU_NAND: begin
                res.value = ~(opA & opB);
            end
            ALU_NOR: begin
                res.value = ~(opA | opB);
            end
            ALU_XNOR: begin
                res.value = ~(opA ^ opB);
            end
            ALU_ANDN: begin
                res.value = opA & ~opB;
            end
            ALU_ORN: begin
                res.value = opA | ~opB;
            end
            ALU_XORN: begin
                res.value = opA ^ ~opB;
            end
            ALU_NOT: begin
                res.value = ~opA;
            end
            ALU_SLL: begin
                res.value = opA << shamt;
            end
            ALU_SRL: begin
                res.value = opA >> shamt;
            end
            ALU_SRA: begin
                res.value = $signed(opA) >>> shamt;
            end
            ALU_ROL: begin
                res.value = rotLeft[2*`ALU_WIDTH-1:`ALU_WIDTH];
            end
            ALU_ROR: begin
                res.value = rotRight[`ALU_WIDTH-1:0];
            end
            ALU_CLZ: begin
                res.value = `ALU_WIDTH'(leadZeros);
            end
            ALU_CTZ: begin
                res.value = `ALU_WIDTH'(trailZeros);
            end
            ALU_PCNT: begin
                res.value = `ALU_WIDTH'(onesCount);
            end
            ALU_BITREV: begin
                res.value = bitRev;
            end
            ALU_BSWAP: begin
                res.value = byteSwap;
            end
            default: ;
        endcase
    end

endmodule

/* hw/ResultStage.sv */
`include "alu_params.svh"

module ResultStage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  aluOpPkg::aluUnit_e         unit,
    input  aluResultPkg::unitResult_s  arith,
    input  aluResultPkg::unitResult_s  logical,
    output aluResultPkg::aluResponse_s rsp
);
    import aluOpPkg::*;
    import aluResultPkg::*;

    unitResult_s                chosen;
    logic                       evenParity;
    logic [`ALU_FLAG_COUNT-1:0] flagWord;

    always_comb begin
        chosen = '0;
        case (unit)
            UNIT_ARITH: begin
                chosen = arith;
            end
            UNIT_LOGIC, UNIT_BITS: begin
                chosen.value = logical.value; // carry and overflow stay clear.
            end
            default: ;
        endcase
    end

    assign evenParity = ~^chosen.value;

    // bits are packed in the same order as aluFlags_s.
    always_comb begin
        if (unit == UNIT_NONE) begin
            flagWord = '0; // a NOP reports no flags at all, not even zero.
        end else begin
            flagWord = {chosen.carryOut, chosen.overflow, evenParity, ~evenParity,
                        chosen.value[`ALU_WIDTH-1], ~|chosen.value};
        end
    end

    // result and flags hold between requests while the valid bit drops.
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp.outValid <= enable;
            if (enable) begin
                rsp.result <= chosen.value;
                rsp.flags  <= flagWord;
            end
        end
    end

endmodule

/* hw/ALU.sv */
module ALU (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  aluResultPkg::aluRequest_s  req,
    output aluResultPkg::aluResponse_s rsp
);
    import aluOpPkg::*;
    import aluResultPkg::*;

    unitResult_s arithRes;
    unitResult_s logicRes;
    aluUnit_e    unit;

    // the fields view of the opcode picks the unit.
    assign unit = unitOf(req.op);

    // both units see every request and the stage keeps one answer.
    ArithmeticOps arithmeticOps (
        .op (req.op.op),
        .opA(req.opA),
        .opB(req.opB),
        .cIn(req.cIn),
        .res(arithRes)
    );

    LogicOps logicOps (
        .op (req.op.op),
        .opA(req.opA),
        .opB(req.opB),
        .res(logicRes)
    );

    ResultStage resultStage (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .unit   (unit),
        .arith  (arithRes),
        .logical(logicRes),
        .rsp    (rsp)
    );

endmodule

/* tests/clockGen.sv */
module clockGen #(
    parameter int halfPeriod = 5
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

/* tests/alu_sva.sv */
module alu_sva (
    input logic                       clk,
    input logic                       reset,
    input logic                       enable,
    input aluOpPkg::aluUnit_e         unit,
    input aluResultPkg::aluResponse_s rsp
);
    import aluOpPkg::*;

    // one response per request, exactly one cycle later.
    validAfterEnable: assert property (@(posedge clk) disable iff (reset)
        enable |=> rsp.outValid)
        else $error("outValid did not follow enable by one cycle");

    noValidWithoutEnable: assert property (@(posedge clk) disable iff (reset)
        !enable |=> !rsp.outValid)
        else $error("outValid rose without a request");

    validLowAfterReset: assert property (@(posedge clk)
        reset |=> !rsp.outValid)
        else $error("outValid high in the cycle after reset");

    // a NOP leaves every flag clear, so it is left out here.
    flagsMatchResult: assert property (@(posedge clk) disable iff (reset)
        (rsp.outValid && $past(unit) != UNIT_NONE)
            |-> (rsp.flags.zero == (rsp.result == '0))
                && (rsp.flags.evenParity != rsp.flags.oddParity))
        else $error("zero or parity flags disagree with the result");

endmodule

/* tests/aluTb.sv */
`include "alu_params.svh"

module aluTb;
    import aluOpPkg::*;
    import aluResultPkg::*;

    localparam int opWidth      = `ALU_UNIT_WIDTH + `ALU_FUNC_WIDTH;
    localparam int validTimeout = 1; // cycles from the request to outValid.
    localparam int resetCycles  = 4;
    localparam int randomCount  = 50;

    localparam logic [`ALU_WIDTH-1:0] patA   = 32'hFF00_F0F0;
    localparam logic [`ALU_WIDTH-1:0] patB   = 32'h0F0F_00FF;
    localparam logic [`ALU_WIDTH-1:0] shiftA = 32'h8000_0001;

    typedef struct {
        string                      name;
        logic [opWidth-1:0]         code;
        logic [`ALU_WIDTH-1:0]      opA;
        logic [`ALU_WIDTH-1:0]      opB;
        logic                       cIn;
        logic [`ALU_WIDTH-1:0]      result;
        logic [`ALU_FLAG_COUNT-1:0] flags;
    } tableEntry_s;

    logic         clk;
    logic         reset;
    logic         enable;
    aluRequest_s  req;
    aluResponse_s rsp;

    tableEntry_s  vectors[$];
    logic [31:0]  rngState;
    int           passCount;
    int           failCount;

    clockGen clockGen_i (.clk(clk));

    ALU dut_i (
        .clk   (clk),
        .reset (reset),
        .enable(enable),
        .req   (req),
        .rsp   (rsp)
    );

    bind ALU alu_sva aluSva (.clk(clk), .reset(reset), .enable(enable), .unit(unit), .rsp(rsp));

    // flag word in the order carry, overflow, even, odd, sign, zero.
    function automatic logic [`ALU_FLAG_COUNT-1:0] flagsOf(input logic [`ALU_WIDTH-1:0] value,
                                                         input logic carry,
                                                         input logic overflow);
        int   ones;
        logic even;
        ones = 0;
        for (int i = 0; i < `ALU_WIDTH; i++) begin
            if (value[i]) begin
                ones++;
            end
        end
        even = (ones % 2) == 0;
        return {carry, overflow, even, ~even, value[`ALU_WIDTH-1], value == '0};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic addVector(input string name, input logic [opWidth-1:0] code,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] result, input logic carry = 1'b0,
                             input logic overflow = 1'b0, input logic cIn = 1'b0);
        vectors.push_back('{name, code, a, b, cIn, result, flagsOf(result, carry, overflow)});
    endtask

    task automatic loadTable();
        addVector("add", ALU_ADD, 32'd5, 32'd7, 32'd12);
        addVector("add cin", ALU_ADD, 32'd5, 32'd7, 32'd13, 1'b0, 1'b0, 1'b1);
        addVector("add carry", ALU_ADD, 32'hFFFF_FFFF, 32'd1, 32'h0, 1'b1, 1'b0);
        addVector("add overflow", ALU_ADD, 32'h7FFF_FFFF, 32'd1, 32'h8000_0000, 1'b0, 1'b1);
        addVector("sub", ALU_SUB, 32'd10, 32'd3, 32'd7);
        addVector("sub borrow", ALU_SUB, 32'd3, 32'd10, 32'hFFFF_FFF9, 1'b1, 1'b0);
        addVector("sub cin", ALU_SUB, 32'd10, 32'd3, 32'd6, 1'b0, 1'b0, 1'b1);
        addVector("inca carry", ALU_INCA, 32'hFFFF_FFFF, 32'h1234, 32'h0, 1'b1, 1'b0);
        addVector("deca borrow", ALU_DECA, 32'h0, 32'h1234, 32'hFFFF_FFFF, 1'b1, 1'b0);
        addVector("neg", ALU_NEG, 32'd5, 32'd0, 32'hFFFF_FFFB);
        addVector("abs", ALU_ABS, 32'hFFFF_FFF6, 32'd0, 32'd10);
        addVector("abs min", ALU_ABS, 32'h8000_0000, 32'd0, 32'h8000_0000, 1'b0, 1'b1);
        addVector("slt", ALU_SLT, 32'hFFFF_FFFF, 32'd1, 32'd1);
        addVector("sltu", ALU_SLTU, 32'hFFFF_FFFF, 32'd1, 32'd0);
        addVector("min", ALU_MIN, 32'hFFFF_FFFB, 32'd3, 32'hFFFF_FFFB);
        addVector("minu", ALU_MINU, 32'hFFFF_FFFB, 32'd3, 32'd3);
        addVector("max", ALU_MAX, 32'hFFFF_FFFB, 32'd3, 32'd3);
        addVector("maxu", ALU_MAXU, 32'hFFFF_FFFB, 32'd3, 32'hFFFF_FFFB);
        addVector("and", ALU_AND, patA, patB, 32'h0F00_00F0);
        addVector("or", ALU_OR, patA, patB, 32'hFF0F_F0FF);
        addVector("xor", ALU_XOR, patA, patB, 32'hF00F_F00F);
        addVector("nand", ALU_NAND, patA, patB, 32'hF0FF_FF0F);
        addVector("nor", ALU_NOR, patA, patB, 32'h00F0_0F00);
        addVector("xnor", ALU_XNOR, patA, patB, 32'h0FF0_0FF0);
        addVector("andn", ALU_ANDN, patA, patB, 32'hF000_F000);
        addVector("orn", ALU_ORN, patA, patB, 32'hFFF0_FFF0);
        addVector("xorn", ALU_XORN, patA, patB, 32'h0FF0_0FF0);
        addVector("not", ALU_NOT, patA, patB, 32'h00FF_0F0F);
        vectors.push_back('{"nop", 6'h00, 32'h1234, 32'h5678, 1'b1, 32'h0, 6'h0});
        vectors.push_back('{"unlisted mul code", 6'h1c, 32'd6, 32'd7, 1'b0, 32'h0, 6'h0});
        addVector("sll 0", ALU_SLL, shiftA, 32'd0, 32'h8000_0001);
        addVector("sll 1", ALU_SLL, shiftA, 32'h21, 32'h0000_0002); // only 5 bits count.
        addVector("sll 31", ALU_SLL, shiftA, 32'd31, 32'h8000_0000);
        addVector("srl 1", ALU_SRL, shiftA, 32'd1, 32'h4000_0000);
        addVector("srl 31", ALU_SRL, shiftA, 32'd31, 32'h0000_0001);
        addVector("sra 1", ALU_SRA, shiftA, 32'd1, 32'hC000_0000);
        addVector("sra 31", ALU_SRA, shiftA, 32'd31, 32'hFFFF_FFFF);
        addVector("rol 1", ALU_ROL, shiftA, 32'd1, 32'h0000_0003);
        addVector("rol 31", ALU_ROL, shiftA, 32'd31, 32'hC000_0000);
        addVector("ror 0", ALU_ROR, shiftA, 32'd0, 32'h8000_0001);
        addVector("ror 1", ALU_ROR, shiftA, 32'd1, 32'hC000_0000);
        addVector("ror 31", ALU_ROR, shiftA, 32'd31, 32'h0000_0003);
        addVector("clz zero", ALU_CLZ, 32'h0, 32'd0, 32'd32);
        addVector("clz bit", ALU_CLZ, 32'h0001_0000, 32'd0, 32'd15);
        addVector("ctz zero", ALU_CTZ, 32'h0, 32'd0, 32'd32);
        addVector("ctz bit", ALU_CTZ, 32'h0001_0000, 32'd0, 32'd16);
        addVector("pcnt", ALU_PCNT, 32'hF0F0_1234, 32'd0, 32'd13);
        addVector("bitrev", ALU_BITREV, 32'h1234_5678, 32'd0, 32'h1E6A_2C48);
        addVector("bswap", ALU_BSWAP, 32'h1234_5678, 32'd0, 32'h7856_3412);
    endtask

    task automatic tallyTest(input string name, input bit ok);
        if (ok) begin
            passCount++;
            $display("[PASS] %s", name);
        end else begin
            failCount++;
        end
    endtask

    task automatic runVector(input tableEntry_s v);
        int waited;
        bit seen;
        bit ok;
        waited = 0;
        seen = 1'b0;
        ok = 1'b1;
        @(negedge clk);
        enable = 1'b1;
        req.opA = v.opA;
        req.opB = v.opB;
        req.cIn = v.cIn;
        req.op = v.code;
        while (!seen && waited < validTimeout) begin
            @(negedge clk);
            enable = 1'b0;
            waited++;
            seen = rsp.outValid === 1'b1;
        end
        if (!seen) begin
            $display("%s: no outValid within %0d cycle of the request", v.name, validTimeout);
            ok = 1'b0;
        end else begin
            if (rsp.result !== v.result) begin
                $display("[FAIL] %s: result expected %h actual %h", v.name, v.result, rsp.result);
                ok = 1'b0;
            end
            if (rsp.flags !== v.flags) begin
                $display("[FAIL] %s: flags expected %b actual %b", v.name, v.flags, rsp.flags);
                ok = 1'b0;
            end
        end
        tallyTest(v.name, ok);
    endtask

    // without enable the valid bit stays low and the last answer is held.
    task automatic checkIdle(input string name, input int cycles,
                             input logic [31:0] result, input logic [5:0] flags);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (rsp.outValid !== 1'b0) begin
                $display("%s: outValid is high although no request was made", name);
                ok = 1'b0;
            end
            if (rsp.result !== result) begin
                $display("[FAIL] %s: result expected %h actual %h", name, result, rsp.result);
                ok = 1'b0;
            end
            if (rsp.flags !== flags) begin
                $display("[FAIL] %s: flags expected %b actual %b", name, flags, rsp.flags);
                ok = 1'b0;
            end
        end
        tallyTest(name, ok);
    endtask

    task automatic runRandomBurst();
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] sum;
        logic        useAdd;
        logic        addOverflow;
        logic [31:0] expResult;
        logic [5:0]  expFlags;
        bit          ok;
        ok = 1'b1;
        expResult = '0;
        expFlags = '0;
        for (int i = 0; i <= randomCount; i++) begin
            @(negedge clk);
            if (i > 0) begin
                if (rsp.outValid !== 1'b1) begin
                    $display("random burst: no outValid on the cycle after request %0d", i - 1);
                    ok = 1'b0;
                end
                if (rsp.result !== expResult) begin
                    $display("[FAIL] random %0d: result expected %h actual %h",
                             i - 1, expResult, rsp.result);
                    ok = 1'b0;
                end
                if (rsp.flags !== expFlags) begin
                    $display("[FAIL] random %0d: flags expected %b actual %b",
                             i - 1, expFlags, rsp.flags);
                    ok = 1'b0;
                end
            end
            enable = 1'b0;
            if (i < randomCount) begin
                rngState = xorshift32(rngState);
                a = rngState;
                rngState = xorshift32(rngState);
                b = rngState;
                rngState = xorshift32(rngState);
                useAdd = rngState[0];
                req.cIn = rngState[1];
                sum = {1'b0, a} + {1'b0, b} + 33'(req.cIn);
                if (useAdd) begin
                    // signed overflow when both operands share a sign the sum lacks.
                    addOverflow = (a[31] == b[31]) && (sum[31] != a[31]);
                    expResult = sum[31:0];
                    expFlags = flagsOf(sum[31:0], sum[32], addOverflow);
                    req.op = ALU_ADD;
                end else begin
                    expResult = a ^ b;
                    expFlags = flagsOf(a ^ b, 1'b0, 1'b0);
                    req.op = ALU_XOR;
                end
                req.opA = a;
                req.opB = b;
                enable = 1'b1;
            end
        end
        tallyTest("random back-to-back", ok);
    endtask

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        req = '0;
        passCount = 0;
        failCount = 0;
        rngState = 32'd44;
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b0;
        checkIdle("reset and idle", 3, '0, '0);

        loadTable();
        foreach (vectors[i]) begin
            runVector(vectors[i]);
        end
        checkIdle("idle hold", 2, vectors[$].result, vectors[$].flags);

        runRandomBurst();

        // a reset in the middle of a run clears the held answer too.
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        reset = 1'b0;
        checkIdle("reset clears output", 2, '0, '0);

        $display("%0d tests ok, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/aluOpPkg.sv
hw/aluResultPkg.sv
hw/ArithmeticOps.sv
hw/LogicOps.sv
hw/ResultStage.sv
hw/ALU.sv
tests/clockGen.sv
tests/alu_sva.sv
tests/aluTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module aluTb -o aluTb -f verilog.f \
    || { echo "build failed"; exit 1; }

simOut="$(./obj_dir/aluTb 2>&1)"
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
